// ==== Makefile ====
# Verilator build, run and lint for the sort_shim testbench
# Any variable below can be overridden, e.g. make LOG=run2.log

VERILATOR  ?= verilator
TOP        ?= tb_sort_shim
FILELIST   ?= sort_shim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so the exit status of the binary is not used
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo
    import sort_pkg::*;
#(
    parameter type payload_t = rd_req_t
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     enq_en,
    input  payload_t enq_data,
    output logic     alm_full,

    input  logic     deq_en,
    output logic     not_empty,
    output payload_t first
);

    // The storage array is written at the tail and read at the head
    payload_t mem [REQ_DEPTH];

    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;

    // Occupancy needs one extra bit so that a full FIFO is distinct from empty
    logic [REQ_CNT_W-1:0] count;

    // Payload write into the tail slot
    always_ff @(posedge clk) begin
        if (enq_en) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head is visible the cycle after it was written
    assign not_empty = (count != '0);
    assign first     = mem[rd_ptr];

    // Upstream sees the level early, so requests already on the way still fit
    assign alm_full  = (count >= REQ_CNT_W'(REQ_ALM_FULL));

    // A simultaneous dequeue frees the slot that a full FIFO overwrites
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        enq_en && (count == REQ_CNT_W'(REQ_DEPTH)) |-> deq_en);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        deq_en |-> not_empty);

endmodule

// ==== logic/rsp_merge.sv ====
`timescale 1ns/1ps

module rsp_merge
    import sort_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,

    // Unbuffered write completions from memory
    input  logic               wr_rsp_valid,
    input  logic [MDATA_W-1:0] wr_rsp_mdata,

    // Sorted read completions from the scoreboard head
    input  logic               sb_not_empty,
    input  logic [DATA_W-1:0]  sb_data,
    input  logic [MDATA_W-1:0] sb_meta,
    output logic               sb_deq,

    // Single response port toward the accelerator
    output logic               rsp_valid,
    output rsp_kind_t          rsp_kind,
    output logic [MDATA_W-1:0] rsp_mdata,
    output logic [DATA_W-1:0]  rsp_data
);

    // Write responses have nowhere to wait, so a ready read holds in the
    // scoreboard for a cycle instead
    assign sb_deq = sb_not_empty && !wr_rsp_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= wr_rsp_valid || sb_deq;
        end
    end

    // Response fields. Data is only refreshed for reads and holds otherwise
    always_ff @(posedge clk) begin
        if (wr_rsp_valid) begin
            rsp_kind  <= RSP_WRITE;
            rsp_mdata <= wr_rsp_mdata;
        end else if (sb_deq) begin
            rsp_kind  <= RSP_READ;
            rsp_mdata <= sb_meta;
            rsp_data  <= sb_data;
        end
    end

    // The accelerator decodes kind and mdata on every valid beat
    a_kind_known: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !$isunknown({rsp_kind, rsp_mdata}));

endmodule

// ==== logic/rsp_scoreboard.sv ====
`timescale 1ns/1ps

module rsp_scoreboard
    import sort_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // One entry is allocated per issued read
    input  logic                enq_en,
    input  logic [MDATA_W-1:0]  enq_meta,
    output logic                not_full,
    output logic [SB_IDX_W-1:0] enq_idx,

    // Fills are indexed by the tag coming back from memory
    input  logic                fill_en,
    input  logic [SB_IDX_W-1:0] fill_idx,
    input  logic [DATA_W-1:0]   fill_data,

    // Release always takes the oldest entry
    input  logic                deq_en,
    output logic                not_empty,
    output logic [DATA_W-1:0]   first_data,
    output logic [MDATA_W-1:0]  first_meta
);

    // ========================================================================
    // Entry state
    // ========================================================================

    // Per-entry flags. An entry is allocated from issue until release,
    // and filled from its memory response until release
    logic [SB_ENTRIES-1:0] allocated;
    logic [SB_ENTRIES-1:0] filled;

    // Both pointers walk the ring in the same direction
    logic [SB_IDX_W-1:0]   alloc_ptr;
    logic [SB_IDX_W-1:0]   rel_ptr;

    // Metadata saved at allocation and data returned by memory
    logic [MDATA_W-1:0]    meta_mem [SB_ENTRIES];
    logic [DATA_W-1:0]     data_mem [SB_ENTRIES];

    // ========================================================================
    // Payload arrays
    // ========================================================================

    // Metadata is captured at allocation so the original mdata can be
    // put back on the response
    always_ff @(posedge clk) begin
        if (enq_en) begin
            meta_mem[alloc_ptr] <= enq_meta;
        end
    end

    // Data may land in any allocated slot, in any order
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[fill_idx] <= fill_data;
        end
    end

    // ========================================================================
    // Control flags and pointers
    // ========================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            allocated <= '0;
            filled    <= '0;
            alloc_ptr <= '0;
            rel_ptr   <= '0;
        end else begin
            // New entries always come from the tail of the ring
            if (enq_en) begin
                allocated[alloc_ptr] <= 1'b1;
                alloc_ptr            <= alloc_ptr + 1'b1;
            end

            // Memory may complete entries out of order
            if (fill_en) begin
                filled[fill_idx] <= 1'b1;
            end

            // Release frees the head. It never collides with the writes
            // above, since a filled entry is neither free nor fillable
            if (deq_en) begin
                allocated[rel_ptr] <= 1'b0;
                filled[rel_ptr]    <= 1'b0;
                rel_ptr            <= rel_ptr + 1'b1;
            end
        end
    end

    // Full once the tail wraps onto a slot that is still live
    assign not_full   = !allocated[alloc_ptr];
    assign enq_idx    = alloc_ptr;

    // Only the oldest entry may leave, which restores request order
    assign not_empty  = filled[rel_ptr];
    assign first_data = data_mem[rel_ptr];
    assign first_meta = meta_mem[rel_ptr];

    // A response tag must name a read that is actually outstanding
    a_fill_allocated: assert property (@(posedge clk) disable iff (!rst_n)
        fill_en |-> allocated[fill_idx]);

    // Memory returns each read exactly once
    a_no_double_fill: assert property (@(posedge clk) disable iff (!rst_n)
        fill_en |-> !filled[fill_idx]);

    a_no_enq_full: assert property (@(posedge clk) disable iff (!rst_n)
        enq_en |-> not_full);

endmodule

// ==== logic/sort_pkg.sv ====
package sort_pkg;

    // ========================================================================
    // Widths, depths and thresholds
    // ========================================================================

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int MDATA_W    = 8;

    // Scoreboard size and the matching tag width sent to memory
    localparam int SB_ENTRIES = 16;
    localparam int SB_IDX_W   = 4;

    // Request FIFO geometry
    localparam int REQ_DEPTH  = 8;
    localparam int REQ_PTR_W  = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W  = REQ_PTR_W + 1;

    // Two slots of slack remain above this level for requests in flight
    localparam int REQ_ALM_FULL = 6;

    // ========================================================================
    // Payload and response types
    // ========================================================================

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [MDATA_W-1:0] mdata;
    } rd_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  data;
        logic [MDATA_W-1:0] mdata;
    } wr_req_t;

    typedef enum logic {
        RSP_READ  = 1'b0,
        RSP_WRITE = 1'b1
    } rsp_kind_t;

endpackage

// ==== logic/sort_shim.sv ====
`timescale 1ns/1ps

module sort_shim
    import sort_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // Accelerator requests and their flow-control levels
    input  logic                rd_req_valid,
    input  logic [ADDR_W-1:0]   rd_req_addr,
    input  logic [MDATA_W-1:0]  rd_req_mdata,
    input  logic                wr_req_valid,
    input  logic [ADDR_W-1:0]   wr_req_addr,
    input  logic [DATA_W-1:0]   wr_req_data,
    input  logic [MDATA_W-1:0]  wr_req_mdata,
    output logic                rd_alm_full,
    output logic                wr_alm_full,

    // Requests toward memory
    output logic                mem_rd_valid,
    output logic [ADDR_W-1:0]   mem_rd_addr,
    output logic [SB_IDX_W-1:0] mem_rd_tag,
    output logic                mem_wr_valid,
    output logic [ADDR_W-1:0]   mem_wr_addr,
    output logic [DATA_W-1:0]   mem_wr_data,
    output logic [MDATA_W-1:0]  mem_wr_mdata,
    input  logic                mem_rd_alm_full,
    input  logic                mem_wr_alm_full,

    // Responses from memory with reads possibly out of order
    input  logic                mem_rd_rsp_valid,
    input  logic [SB_IDX_W-1:0] mem_rd_rsp_tag,
    input  logic [DATA_W-1:0]   mem_rd_rsp_data,
    input  logic                mem_wr_rsp_valid,
    input  logic [MDATA_W-1:0]  mem_wr_rsp_mdata,

    // Ordered responses toward the accelerator
    output logic                rsp_valid,
    output rsp_kind_t           rsp_kind,
    output logic [MDATA_W-1:0]  rsp_mdata,
    output logic [DATA_W-1:0]   rsp_data
);

    // ========================================================================
    // Request FIFOs
    // ========================================================================

    rd_req_t rd_in;
    rd_req_t rd_head;
    wr_req_t wr_in;
    wr_req_t wr_head;
    logic    rd_rdy;
    logic    wr_rdy;
    logic    issue;

    assign rd_in = '{addr: rd_req_addr, mdata: rd_req_mdata};
    assign wr_in = '{addr: wr_req_addr, data: wr_req_data, mdata: wr_req_mdata};

    req_fifo #(.payload_t(rd_req_t)) rd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq_en    (rd_req_valid),
        .enq_data  (rd_in),
        .alm_full  (rd_alm_full),
        .deq_en    (issue && rd_rdy),
        .not_empty (rd_rdy),
        .first     (rd_head)
    );

    req_fifo #(.payload_t(wr_req_t)) wr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq_en    (wr_req_valid),
        .enq_data  (wr_in),
        .alm_full  (wr_alm_full),
        .deq_en    (issue && wr_rdy),
        .not_empty (wr_rdy),
        .first     (wr_head)
    );

    // ========================================================================
    // Lockstep issue
    // ========================================================================

    logic                sb_not_full;
    logic [SB_IDX_W-1:0] sb_enq_idx;
    logic                rd_blocked;
    logic                wr_blocked;

    // A read also needs a free scoreboard slot to carry its tag
    assign rd_blocked = rd_rdy && (mem_rd_alm_full || !sb_not_full);
    assign wr_blocked = wr_rdy && mem_wr_alm_full;

    // Either channel stalling holds both, keeping reads and writes ordered
    // relative to each other
    assign issue = (rd_rdy || wr_rdy) && !(rd_blocked || wr_blocked);

    // Memory sees the slot index as the tag while the mdata stays behind
    assign mem_rd_valid = issue && rd_rdy;
    assign mem_rd_addr  = rd_head.addr;
    assign mem_rd_tag   = sb_enq_idx;

    // Writes pass through untouched
    assign mem_wr_valid = issue && wr_rdy;
    assign mem_wr_addr  = wr_head.addr;
    assign mem_wr_data  = wr_head.data;
    assign mem_wr_mdata = wr_head.mdata;

    // ========================================================================
    // Reorder buffer and response port
    // ========================================================================

    logic               sb_not_empty;
    logic               sb_deq;
    logic [DATA_W-1:0]  sb_data;
    logic [MDATA_W-1:0] sb_meta;

    rsp_scoreboard scoreboard (
        .clk        (clk),
        .rst_n      (rst_n),
        .enq_en     (mem_rd_valid),
        .enq_meta   (rd_head.mdata),
        .not_full   (sb_not_full),
        .enq_idx    (sb_enq_idx),
        .fill_en    (mem_rd_rsp_valid),
        .fill_idx   (mem_rd_rsp_tag),
        .fill_data  (mem_rd_rsp_data),
        .deq_en     (sb_deq),
        .not_empty  (sb_not_empty),
        .first_data (sb_data),
        .first_meta (sb_meta)
    );

    rsp_merge merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_rsp_valid (mem_wr_rsp_valid),
        .wr_rsp_mdata (mem_wr_rsp_mdata),
        .sb_not_empty (sb_not_empty),
        .sb_data      (sb_data),
        .sb_meta      (sb_meta),
        .sb_deq       (sb_deq),
        .rsp_valid    (rsp_valid),
        .rsp_kind     (rsp_kind),
        .rsp_mdata    (rsp_mdata),
        .rsp_data     (rsp_data)
    );

    // Memory back-pressure must hold reads at the FIFO head
    a_rd_respects_mem: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_alm_full && rd_rdy |=> rd_rdy && (rd_head == $past(rd_head)));

endmodule

// ==== sort_shim.f ====
logic/sort_pkg.sv
logic/req_fifo.sv
logic/rsp_scoreboard.sv
logic/rsp_merge.sv
logic/sort_shim.sv
verif/tb_clock.sv
verif/tb_sort_shim.sv

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 4;

    // Free-running 10 ns clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset spans four rising edges and lets go on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verif/tb_sort_shim.sv ====
`timescale 1ns/1ps

module tb_sort_shim
    import sort_pkg::*;
;

    // ========================================================================
    // Run lengths and memory model delays
    // ========================================================================

    localparam int N_IN_ORDER   = 12;
    localparam int N_SHUFFLED   = 14;
    localparam int N_MIXED      = 8;
    localparam int STALL_CHECKS = 6;
    localparam int WR_RSP_DELAY = 3;

    // The abort limit is twice the summed cycle budgets of the tests
    localparam int T_RESET = 20;
    localparam int T_IN_ORDER = 200;
    localparam int T_SHUFFLED = 300;
    localparam int T_MIXED = 300;
    localparam int T_BACKPR = 200;
    localparam int T_SB_FULL = 300;
    localparam int TIMEOUT_CYCLES =
        2 * (T_RESET + T_IN_ORDER + T_SHUFFLED + T_MIXED + T_BACKPR + T_SB_FULL);

    logic clk;
    logic rst_n;

    logic                rd_req_valid;
    logic [ADDR_W-1:0]   rd_req_addr;
    logic [MDATA_W-1:0]  rd_req_mdata;
    logic                wr_req_valid;
    logic [ADDR_W-1:0]   wr_req_addr;
    logic [DATA_W-1:0]   wr_req_data;
    logic [MDATA_W-1:0]  wr_req_mdata;
    logic                rd_alm_full;
    logic                wr_alm_full;
    logic                mem_rd_valid;
    logic [ADDR_W-1:0]   mem_rd_addr;
    logic [SB_IDX_W-1:0] mem_rd_tag;
    logic                mem_wr_valid;
    logic [ADDR_W-1:0]   mem_wr_addr;
    logic [DATA_W-1:0]   mem_wr_data;
    logic [MDATA_W-1:0]  mem_wr_mdata;
    logic                mem_rd_alm_full;
    logic                mem_wr_alm_full;
    logic                mem_rd_rsp_valid;
    logic [SB_IDX_W-1:0] mem_rd_rsp_tag;
    logic [DATA_W-1:0]   mem_rd_rsp_data;
    logic                mem_wr_rsp_valid;
    logic [MDATA_W-1:0]  mem_wr_rsp_mdata;
    logic                rsp_valid;
    rsp_kind_t           rsp_kind;
    logic [MDATA_W-1:0]  rsp_mdata;
    logic [DATA_W-1:0]   rsp_data;

    // The tests set these memory model knobs on a falling edge
    logic hold_rsp;
    logic shuffle_rsp;

    // Expected responses are only appended and stay in accelerator order
    logic [MDATA_W-1:0] exp_rd_mdata [$];
    logic [ADDR_W-1:0]  exp_rd_addr [$];
    logic [MDATA_W-1:0] exp_wr_mdata [$];
    int rd_chk = 0;
    int wr_chk = 0;
    int cycle_cnt = 0;

    // Writes as the accelerator sent them, checked when memory sees them
    logic [ADDR_W-1:0]  exp_wr_addr [$];
    logic [DATA_W-1:0]  exp_wr_data [$];
    int wr_iss_chk = 0;

    // Write responses that went out while a read was still owed
    int overlap_cnt = 0;

    // Memory model state. Reads in flight sit in issue order
    logic [SB_IDX_W-1:0] pend_tag [SB_ENTRIES];
    logic [ADDR_W-1:0]   pend_addr [SB_ENTRIES];
    logic [MDATA_W-1:0]  wr_echo_mdata [$];
    int wr_echo_due [$];
    int pend_cnt;
    int issued_cnt;
    int reorder_cnt;
    int mem_cycle;
    logic [15:0] lfsr_state = 16'd66;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sort_shim dut0 (.*);

    // ========================================================================
    // Helpers
    // ========================================================================

    // Galois LFSR that steps once per bit handed out
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return b;
    endfunction

    function automatic int random_index(input int n);
        int v;
        int k;
        v = 0;
        for (k = 0; k < SB_IDX_W; k++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v % n;
    endfunction

    // Memory content is the address followed by its inverse
    function automatic logic [DATA_W-1:0] line_for(input logic [ADDR_W-1:0] a);
        return {a, ~a};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_read(input logic [MDATA_W-1:0] got_mdata,
                              input logic [MDATA_W-1:0] exp_mdata,
                              input logic [DATA_W-1:0]  got_data,
                              input logic [DATA_W-1:0]  exp_data);
        if (got_mdata !== exp_mdata) begin
            fail_run($sformatf("error rsp_mdata got 0x%h expected 0x%h", got_mdata, exp_mdata));
        end else if (got_data !== exp_data) begin
            fail_run($sformatf("error rsp_data got 0x%h expected 0x%h", got_data, exp_data));
        end
    endtask

    task automatic check_write(input logic [MDATA_W-1:0] got_mdata,
                               input logic [MDATA_W-1:0] exp_mdata);
        if (got_mdata !== exp_mdata) begin
            fail_run($sformatf("error rsp_mdata got 0x%h expected 0x%h", got_mdata, exp_mdata));
        end
    endtask

    task automatic check_mem_write(input logic [ADDR_W-1:0] got_addr,
                                   input logic [ADDR_W-1:0] exp_addr,
                                   input logic [DATA_W-1:0] got_data,
                                   input logic [DATA_W-1:0] exp_data);
        if (got_addr !== exp_addr) begin
            fail_run($sformatf("error mem_wr_addr got 0x%h expected 0x%h",
                               got_addr, exp_addr));
        end else if (got_data !== exp_data) begin
            fail_run($sformatf("error mem_wr_data got 0x%h expected 0x%h",
                               got_data, exp_data));
        end
    endtask

    task automatic expect_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // One read per falling edge that is held off while the shim reports almost full
    task automatic read_request(input logic [ADDR_W-1:0] addr, input logic [MDATA_W-1:0] mdata);
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        while (rd_alm_full) @(negedge clk);
        rd_req_valid = 1'b1;
        rd_req_addr  = addr;
        rd_req_mdata = mdata;
        exp_rd_mdata.push_back(mdata);
        exp_rd_addr.push_back(addr);
    endtask

    task automatic write_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                 input logic [MDATA_W-1:0] mdata);
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
        while (wr_alm_full) @(negedge clk);
        wr_req_valid = 1'b1;
        wr_req_addr  = addr;
        wr_req_data  = data;
        wr_req_mdata = mdata;
        exp_wr_mdata.push_back(mdata);
        exp_wr_addr.push_back(addr);
        exp_wr_data.push_back(data);
    endtask

    task automatic release_requests();
        @(negedge clk);
        rd_req_valid = 1'b0;
        wr_req_valid = 1'b0;
    endtask

    // Waits until every expected response was seen
    task automatic drain_responses();
        release_requests();
        while (rd_chk < exp_rd_mdata.size() || wr_chk < exp_wr_mdata.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // ========================================================================
    // Memory model
    // ========================================================================

    // Requests are captured on the rising edge and answered on the falling one
    initial begin : memory_model
        int pick;
        int j;
        logic hold_now;
        logic shuffle_now;
        mem_rd_rsp_valid = 1'b0;
        mem_rd_rsp_tag   = '0;
        mem_rd_rsp_data  = '0;
        mem_wr_rsp_valid = 1'b0;
        mem_wr_rsp_mdata = '0;
        pend_cnt    = 0;
        issued_cnt  = 0;
        reorder_cnt = 0;
        mem_cycle   = 0;
        forever begin
            @(posedge clk);
            mem_cycle++;
            hold_now    = hold_rsp;
            shuffle_now = shuffle_rsp;
            if (mem_rd_valid === 1'b1) begin
                pend_tag[pend_cnt]  = mem_rd_tag;
                pend_addr[pend_cnt] = mem_rd_addr;
                pend_cnt++;
                issued_cnt++;
            end
            if (mem_wr_valid === 1'b1) begin
                if (wr_iss_chk >= exp_wr_addr.size()) begin
                    fail_run("memory saw a write that the accelerator never sent");
                end else begin
                    check_mem_write(mem_wr_addr, exp_wr_addr[wr_iss_chk],
                                    mem_wr_data, exp_wr_data[wr_iss_chk]);
                    wr_iss_chk++;
                end
                wr_echo_mdata.push_back(mem_wr_mdata);
                wr_echo_due.push_back(mem_cycle + WR_RSP_DELAY);
            end
            @(negedge clk);
            mem_rd_rsp_valid = 1'b0;
            mem_wr_rsp_valid = 1'b0;
            // A random bit leaves gaps between read responses
            if (!hold_now && pend_cnt > 0 && lfsr_bit()) begin
                pick = shuffle_now ? random_index(pend_cnt) : 0;
                if (pick != 0) begin
                    reorder_cnt++;
                end
                mem_rd_rsp_valid = 1'b1;
                mem_rd_rsp_tag   = pend_tag[pick];
                mem_rd_rsp_data  = line_for(pend_addr[pick]);
                for (j = pick; j < pend_cnt - 1; j++) begin
                    pend_tag[j]  = pend_tag[j + 1];
                    pend_addr[j] = pend_addr[j + 1];
                end
                pend_cnt--;
            end
            if (wr_echo_due.size() > 0 && wr_echo_due[0] <= mem_cycle) begin
                if (rd_chk < exp_rd_mdata.size()) begin
                    overlap_cnt++;
                end
                mem_wr_rsp_valid = 1'b1;
                mem_wr_rsp_mdata = wr_echo_mdata.pop_front();
                void'(wr_echo_due.pop_front());
            end
        end
    end

    // ========================================================================
    // Response checker and cycle limit
    // ========================================================================

    always @(posedge clk) begin
        if (rst_n === 1'b1 && rsp_valid === 1'b1) begin
            if (rsp_kind == RSP_WRITE) begin
                if (wr_chk >= exp_wr_mdata.size()) begin
                    fail_run("a write response arrived with no write outstanding");
                end else begin
                    check_write(rsp_mdata, exp_wr_mdata[wr_chk]);
                    wr_chk++;
                end
            end else begin
                if (rd_chk >= exp_rd_mdata.size()) begin
                    fail_run("a read response arrived with no read outstanding");
                end else begin
                    check_read(rsp_mdata, exp_rd_mdata[rd_chk],
                               rsp_data, line_for(exp_rd_addr[rd_chk]));
                    rd_chk++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles, the run did not finish", cycle_cnt));
        end
    end

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic reset_state();
        while (rst_n !== 1'b1) @(posedge clk);
        expect_level("mem_rd_valid", mem_rd_valid, 1'b0);
        expect_level("mem_wr_valid", mem_wr_valid, 1'b0);
        expect_level("rsp_valid", rsp_valid, 1'b0);
        expect_level("rd_alm_full", rd_alm_full, 1'b0);
        expect_level("wr_alm_full", wr_alm_full, 1'b0);
    endtask

    task automatic in_order_reads();
        int i;
        @(negedge clk);
        shuffle_rsp = 1'b0;
        for (i = 0; i < N_IN_ORDER; i++) begin
            read_request(ADDR_W'(32'h0000_1000 + i * 64), MDATA_W'(8'h10 + i));
        end
        drain_responses();
    endtask

    // Memory scrambles the order but the accelerator must still see request order
    task automatic shuffled_reads();
        int i;
        @(negedge clk);
        shuffle_rsp = 1'b1;
        for (i = 0; i < N_SHUFFLED; i++) begin
            read_request(ADDR_W'(32'h0000_2000 + i * 64), MDATA_W'(8'h30 + i));
        end
        drain_responses();
        if (reorder_cnt == 0) begin
            fail_run("memory never returned a read out of order");
        end
    endtask

    // Write echoes land among pending reads and win the response port
    task automatic write_priority();
        int i;
        for (i = 0; i < N_MIXED; i++) begin
            read_request(ADDR_W'(32'h0000_4000 + i * 64), MDATA_W'(8'h50 + i));
            write_request(ADDR_W'(32'h0000_8000 + i * 64),
                          64'hC0DE_0000_0000_0000 + DATA_W'(i), MDATA_W'(8'hC0 + i));
        end
        drain_responses();
        if (overlap_cnt == 0) begin
            fail_run("no write response arrived while a read was pending");
        end
    endtask

    task automatic mem_backpressure();
        int i;
        @(negedge clk);
        mem_rd_alm_full = 1'b1;
        for (i = 0; i < REQ_ALM_FULL; i++) begin
            read_request(ADDR_W'(32'h0000_3000 + i * 64), MDATA_W'(8'h70 + i));
        end
        write_request(32'h0000_3800, 64'hFEED_0000_0000_0001, 8'hE0);
        release_requests();
        // The read stall holds the write as well
        repeat (STALL_CHECKS) begin
            @(posedge clk);
            expect_level("mem_rd_valid", mem_rd_valid, 1'b0);
            expect_level("mem_wr_valid", mem_wr_valid, 1'b0);
        end
        expect_level("rd_alm_full", rd_alm_full, 1'b1);
        @(negedge clk);
        mem_rd_alm_full = 1'b0;
        drain_responses();
    endtask

    // One read more than the scoreboard holds while all responses are held back
    task automatic scoreboard_full();
        int i;
        int base;
        @(negedge clk);
        hold_rsp    = 1'b1;
        shuffle_rsp = 1'b0;
        base = issued_cnt;
        for (i = 0; i <= SB_ENTRIES; i++) begin
            read_request(ADDR_W'(32'h0000_5000 + i * 64), MDATA_W'(8'hA0 + i));
        end
        release_requests();
        while (issued_cnt - base < SB_ENTRIES) @(negedge clk);
        repeat (STALL_CHECKS) begin
            @(posedge clk);
            expect_level("mem_rd_valid", mem_rd_valid, 1'b0);
        end
        @(negedge clk);
        hold_rsp = 1'b0;
        drain_responses();
    endtask

    initial begin
        rd_req_valid    = 1'b0;
        rd_req_addr     = '0;
        rd_req_mdata    = '0;
        wr_req_valid    = 1'b0;
        wr_req_addr     = '0;
        wr_req_data     = '0;
        wr_req_mdata    = '0;
        mem_rd_alm_full = 1'b0;
        mem_wr_alm_full = 1'b0;
        hold_rsp        = 1'b0;
        shuffle_rsp     = 1'b0;

        reset_state();
        in_order_reads();
        shuffled_reads();
        write_priority();
        mem_backpressure();
        scoreboard_full();

        if (rd_chk == exp_rd_mdata.size() && wr_chk == exp_wr_mdata.size()) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("responses were still outstanding at the end of the run");
        end
    end

endmodule
